/* mem_pkg.sv */
// memory geometry constants, client operation enum and bist phase enum
package mem_pkg;

    // ####################################################################
    // memory geometry
    // ####################################################################
    localparam int MEM_DW    = 32;                  // bits per word
    localparam int MEM_DEPTH = 64;                  // words in the array
    localparam int MEM_AW    = $clog2(MEM_DEPTH);   // address bits, 6 here

    // ####################################################################
    // client operation
    // ####################################################################
    typedef enum logic {
        MEM_READ  = 1'b0,                           // data back one cycle after grant
        MEM_WRITE = 1'b1                            // lands at end of grant cycle
    } mem_op_t;

    // ####################################################################
    // bist phases, march c- style
    // ####################################################################
    // each read phase runs two sweeps, the second with inverted polarity,
    // so the six march elements fit in four sweep states
    typedef enum logic [2:0] {
        BIST_IDLE    = 3'd0,                        // waiting for bist_start
        BIST_W0_UP   = 3'd1,                        // write 0, ascending
        BIST_R0W1_UP = 3'd2,                        // r0w1 then r1w0, ascending
        BIST_R1W0_DN = 3'd3,                        // r0w1 then r1w0, descending
        BIST_R0_UP   = 3'd4,                        // final read 0, ascending
        BIST_DRAIN   = 3'd5                         // compare the last read
    } bist_state_t;

endpackage

/* mem_dp.sv */
// dual-ported ram with per-bit write mask, bist override mux and registered read
`timescale 1ns/1ps

module mem_dp (
    input  logic                       rd_clk,      // single clock for both ports
    // functional write port
    input  logic                       wr_en,
    input  logic [mem_pkg::MEM_DW-1:0] wr_wem,      // per bit write enable
    input  logic [mem_pkg::MEM_AW-1:0] wr_addr,
    input  logic [mem_pkg::MEM_DW-1:0] wr_din,
    // functional read port
    input  logic                       rd_en,
    input  logic [mem_pkg::MEM_AW-1:0] rd_addr,
    // bist port, wins while bist_en is high
    input  logic                       bist_en,
    input  logic                       bist_we,
    input  logic [mem_pkg::MEM_DW-1:0] bist_wem,
    input  logic [mem_pkg::MEM_AW-1:0] bist_addr,
    input  logic [mem_pkg::MEM_DW-1:0] bist_din,
    // registered read data
    output logic [mem_pkg::MEM_DW-1:0] rd_dout
);

    import mem_pkg::*;

    logic [MEM_DW-1:0] ram [0:MEM_DEPTH-1];         // storage array

    logic              w_en;                        // muxed write enable
    logic [MEM_DW-1:0] w_wem;                       // muxed bit mask
    logic [MEM_AW-1:0] w_addr;                      // muxed write address
    logic [MEM_DW-1:0] w_din;                       // muxed write data
    logic              r_en;                        // muxed read enable
    logic [MEM_AW-1:0] r_addr;                      // muxed read address
    logic [MEM_DW-1:0] r_data;                      // async array output

    // ####################################################################
    // port select
    // ####################################################################
    assign w_en   = bist_en ? bist_we   : wr_en;
    assign w_wem  = bist_en ? bist_wem  : wr_wem;
    assign w_addr = bist_en ? bist_addr : wr_addr;
    assign w_din  = bist_en ? bist_din  : wr_din;
    assign r_addr = bist_en ? bist_addr : rd_addr;  // bist reads where it writes
    assign r_en   = bist_en | rd_en;                // always capture under bist

    // ####################################################################
    // write side
    // ####################################################################
    // masked merge, untouched bits keep their old value
    always_ff @(posedge rd_clk) begin
        if (w_en) begin
            ram[w_addr] <= (ram[w_addr] & ~w_wem) | (w_din & w_wem);
        end
    end

    // ####################################################################
    // read side
    // ####################################################################
    assign r_data = ram[r_addr];                    // combinational lookup

    // same-cycle write to r_addr is not seen, array updates at this edge too
    always_ff @(posedge rd_clk) begin
        if (r_en) begin
            rd_dout <= r_data;                      // one cycle read latency
        end
    end

endmodule

/* mem_arbiter.sv */
// round-robin arbiter for two clients, ram port mux and read data return
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                       rd_clk,
    input  logic                       reset,       // sync, active high
    input  logic                       bist_busy,   // blocks all grants
    // client a
    input  logic                       req_a,       // level, held until gnt_a
    input  mem_pkg::mem_op_t           op_a,
    input  logic [mem_pkg::MEM_AW-1:0] addr_a,
    input  logic [mem_pkg::MEM_DW-1:0] wem_a,
    input  logic [mem_pkg::MEM_DW-1:0] din_a,
    // client b
    input  logic                       req_b,
    input  mem_pkg::mem_op_t           op_b,
    input  logic [mem_pkg::MEM_AW-1:0] addr_b,
    input  logic [mem_pkg::MEM_DW-1:0] wem_b,
    input  logic [mem_pkg::MEM_DW-1:0] din_b,
    // grant pulses
    output logic                       gnt_a,
    output logic                       gnt_b,
    // functional ram port
    output logic                       wr_en,
    output logic [mem_pkg::MEM_DW-1:0] wr_wem,
    output logic [mem_pkg::MEM_AW-1:0] wr_addr,
    output logic [mem_pkg::MEM_DW-1:0] wr_din,
    output logic                       rd_en,
    output logic [mem_pkg::MEM_AW-1:0] rd_addr,
    input  logic [mem_pkg::MEM_DW-1:0] rd_dout,     // registered ram output
    // read return
    output logic                       rd_valid_a,
    output logic                       rd_valid_b,
    output logic [mem_pkg::MEM_DW-1:0] rd_data_a,
    output logic [mem_pkg::MEM_DW-1:0] rd_data_b
);

    import mem_pkg::*;

    logic              last_gnt_b;                  // 1 when b won most recently
    logic              any_gnt;                     // one client granted
    mem_op_t           op_sel;                      // winner's operation
    logic [MEM_AW-1:0] addr_sel;                    // winner's address
    logic              rd_pend;                     // read in flight
    logic              rd_tag_b;                    // read issued by b

    // ####################################################################
    // grant
    // ####################################################################
    // lone requester wins, on a tie the one not granted last wins
    assign gnt_a   = ~bist_busy & req_a & (~req_b | last_gnt_b);
    assign gnt_b   = ~bist_busy & req_b & (~req_a | ~last_gnt_b);
    assign any_gnt = gnt_a | gnt_b;

    always_ff @(posedge rd_clk) begin
        if (reset) begin
            last_gnt_b <= 1'b1;                     // a preferred out of reset
        end else if (any_gnt) begin
            last_gnt_b <= gnt_b;
        end
    end

    // ####################################################################
    // ram port mux
    // ####################################################################
    assign op_sel   = gnt_b ? op_b   : op_a;
    assign addr_sel = gnt_b ? addr_b : addr_a;

    assign wr_en   = any_gnt & (op_sel == MEM_WRITE);
    assign wr_wem  = gnt_b ? wem_b : wem_a;
    assign wr_din  = gnt_b ? din_b : din_a;
    assign wr_addr = addr_sel;                      // same address for either op
    assign rd_en   = any_gnt & (op_sel == MEM_READ);
    assign rd_addr = addr_sel;

    // ####################################################################
    // read return
    // ####################################################################
    always_ff @(posedge rd_clk) begin
        if (reset) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= rd_en;                       // one read per cycle at most
        end
    end

    always_ff @(posedge rd_clk) begin
        rd_tag_b <= gnt_b;                          // only meaningful with rd_pend
    end

    assign rd_valid_a = rd_pend & ~rd_tag_b;
    assign rd_valid_b = rd_pend & rd_tag_b;
    assign rd_data_a  = rd_valid_a ? rd_dout : '0;  // steer data to issuer only
    assign rd_data_b  = rd_valid_b ? rd_dout : '0;

endmodule

/* mem_bist.sv */
// march c- bist engine driving the ram bist port with read-back compare
`timescale 1ns/1ps

module mem_bist (
    input  logic                       rd_clk,
    input  logic                       reset,       // sync, active high
    input  logic                       bist_start,  // one-cycle pulse, idle only
    // status
    output logic                       bist_busy,
    output logic                       bist_done,   // one-cycle pulse at the end
    output logic                       bist_fail,   // sticky until next start
    // ram bist port
    output logic                       bist_en,
    output logic                       bist_we,
    output logic [mem_pkg::MEM_DW-1:0] bist_wem,
    output logic [mem_pkg::MEM_AW-1:0] bist_addr,
    output logic [mem_pkg::MEM_DW-1:0] bist_din,
    input  logic [mem_pkg::MEM_DW-1:0] rd_dout      // read-back, one cycle late
);

    import mem_pkg::*;

    localparam logic [MEM_AW-1:0] ADDR_LAST = MEM_AW'(MEM_DEPTH - 1);

    bist_state_t       state;                       // march phase
    logic              pass;                        // second sweep of a phase
    logic [MEM_AW-1:0] addr;                        // sweep address
    logic              rd_phase;                    // this cycle reads
    logic [MEM_DW-1:0] rd_expect;                   // value this read should see
    logic              cmp_pend;                    // compare due this cycle
    logic [MEM_DW-1:0] exp_data;                    // expected rd_dout

    // ####################################################################
    // march sequencer
    // ####################################################################
    always_ff @(posedge rd_clk) begin
        if (reset) begin
            state <= BIST_IDLE;
            pass  <= 1'b0;
            addr  <= '0;
        end else begin
            case (state)
                BIST_IDLE: begin
                    if (bist_start) begin
                        state <= BIST_W0_UP;
                        pass  <= 1'b0;
                        addr  <= '0;
                    end
                end
                BIST_W0_UP: begin
                    addr <= addr + 1'b1;            // wraps to 0 at the end
                    if (addr == ADDR_LAST) begin
                        state <= BIST_R0W1_UP;
                    end
                end
                BIST_R0W1_UP: begin
                    addr <= addr + 1'b1;
                    if (addr == ADDR_LAST) begin
                        pass <= ~pass;              // r0w1 sweep, then r1w0
                        if (pass) begin
                            state <= BIST_R1W0_DN;
                            addr  <= ADDR_LAST;     // descending next
                        end
                    end
                end
                BIST_R1W0_DN: begin
                    addr <= addr - 1'b1;            // wraps to top between sweeps
                    if (addr == '0) begin
                        pass <= ~pass;
                        if (pass) begin
                            state <= BIST_R0_UP;
                            addr  <= '0;
                        end
                    end
                end
                BIST_R0_UP: begin
                    addr <= addr + 1'b1;
                    if (addr == ADDR_LAST) begin
                        state <= BIST_DRAIN;
                    end
                end
                default: begin
                    state <= BIST_IDLE;             // drain lasts one cycle
                end
            endcase
        end
    end

    // ####################################################################
    // ram drive
    // ####################################################################
    assign bist_busy = (state != BIST_IDLE);
    assign bist_en   = bist_busy;                   // drain keeps the port too
    assign bist_we   = (state == BIST_W0_UP) | (state == BIST_R0W1_UP) |
                       (state == BIST_R1W0_DN);
    assign bist_wem  = {MEM_DW{bist_we}};           // whole word every time
    assign bist_addr = addr;
    // read phases write the complement of what they read
    assign bist_din  = (state == BIST_W0_UP || pass) ? '0 : '1;

    assign rd_phase  = (state == BIST_R0W1_UP) | (state == BIST_R1W0_DN) |
                       (state == BIST_R0_UP);
    assign rd_expect = (rd_phase && state != BIST_R0_UP && pass) ? '1 : '0;

    // ####################################################################
    // compare and status
    // ####################################################################
    always_ff @(posedge rd_clk) begin
        exp_data <= rd_expect;                      // lines up with rd_dout
    end

    always_ff @(posedge rd_clk) begin
        if (reset) begin
            cmp_pend  <= 1'b0;
            bist_fail <= 1'b0;
            bist_done <= 1'b0;
        end else begin
            cmp_pend  <= rd_phase;
            bist_done <= (state == BIST_DRAIN);     // same edge busy drops
            if (state == BIST_IDLE && bist_start) begin
                bist_fail <= 1'b0;                  // fresh run
            end else if (cmp_pend && rd_dout != exp_data) begin
                bist_fail <= 1'b1;
            end
        end
    end

endmodule

/* mem_subsys.sv */
// top level joining two client ports, arbiter, bist engine and ram
`timescale 1ns/1ps

module mem_subsys (
    input  logic                       rd_clk,
    input  logic                       reset,       // sync, active high
    input  logic                       bist_start,
    // client a
    input  logic                       req_a,
    input  mem_pkg::mem_op_t           op_a,
    input  logic [mem_pkg::MEM_AW-1:0] addr_a,
    input  logic [mem_pkg::MEM_DW-1:0] wem_a,
    input  logic [mem_pkg::MEM_DW-1:0] din_a,
    // client b
    input  logic                       req_b,
    input  mem_pkg::mem_op_t           op_b,
    input  logic [mem_pkg::MEM_AW-1:0] addr_b,
    input  logic [mem_pkg::MEM_DW-1:0] wem_b,
    input  logic [mem_pkg::MEM_DW-1:0] din_b,
    // client returns
    output logic                       gnt_a,
    output logic                       gnt_b,
    output logic                       rd_valid_a,
    output logic                       rd_valid_b,
    output logic [mem_pkg::MEM_DW-1:0] rd_data_a,
    output logic [mem_pkg::MEM_DW-1:0] rd_data_b,
    // bist status
    output logic                       bist_busy,
    output logic                       bist_done,
    output logic                       bist_fail
);

    import mem_pkg::*;

    // functional port, arbiter to ram
    logic              wr_en;
    logic [MEM_DW-1:0] wr_wem;
    logic [MEM_AW-1:0] wr_addr;
    logic [MEM_DW-1:0] wr_din;
    logic              rd_en;
    logic [MEM_AW-1:0] rd_addr;
    logic [MEM_DW-1:0] rd_dout;                     // shared by arbiter and bist

    // bist port, engine to ram
    logic              bist_en;
    logic              bist_we;
    logic [MEM_DW-1:0] bist_wem;
    logic [MEM_AW-1:0] bist_addr;
    logic [MEM_DW-1:0] bist_din;

    // ####################################################################
    // blocks
    // ####################################################################
    mem_arbiter mem_arbiter_inst (
        .rd_clk     (rd_clk),
        .reset      (reset),
        .bist_busy  (bist_busy),                    // no grants during test
        .req_a      (req_a),
        .op_a       (op_a),
        .addr_a     (addr_a),
        .wem_a      (wem_a),
        .din_a      (din_a),
        .req_b      (req_b),
        .op_b       (op_b),
        .addr_b     (addr_b),
        .wem_b      (wem_b),
        .din_b      (din_b),
        .gnt_a      (gnt_a),
        .gnt_b      (gnt_b),
        .wr_en      (wr_en),
        .wr_wem     (wr_wem),
        .wr_addr    (wr_addr),
        .wr_din     (wr_din),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_dout    (rd_dout),
        .rd_valid_a (rd_valid_a),
        .rd_valid_b (rd_valid_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b)
    );

    mem_bist mem_bist_inst (
        .rd_clk     (rd_clk),
        .reset      (reset),
        .bist_start (bist_start),
        .bist_busy  (bist_busy),
        .bist_done  (bist_done),
        .bist_fail  (bist_fail),
        .bist_en    (bist_en),
        .bist_we    (bist_we),
        .bist_wem   (bist_wem),
        .bist_addr  (bist_addr),
        .bist_din   (bist_din),
        .rd_dout    (rd_dout)                       // read-back path
    );

    mem_dp mem_dp_inst (
        .rd_clk     (rd_clk),
        .wr_en      (wr_en),
        .wr_wem     (wr_wem),
        .wr_addr    (wr_addr),
        .wr_din     (wr_din),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .bist_en    (bist_en),
        .bist_we    (bist_we),
        .bist_wem   (bist_wem),
        .bist_addr  (bist_addr),
        .bist_din   (bist_din),
        .rd_dout    (rd_dout)
    );

endmodule

/* tb_mem_model.svh */
// shadow memory array with masked-write, expected-read and clear functions
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// ######################################################################
// shadow array
// ######################################################################
logic [MEM_DW-1:0] shadow [0:MEM_DEPTH-1];          // x until written

// bit by bit merge, a set mask bit takes the new data
function automatic logic [MEM_DW-1:0] merge_masked(
    input logic [MEM_DW-1:0] old_word,
    input logic [MEM_DW-1:0] new_word,
    input logic [MEM_DW-1:0] mask
);
    logic [MEM_DW-1:0] result;
    for (int i = 0; i < MEM_DW; i++) begin
        if (mask[i]) begin
            result[i] = new_word[i];                // written bit
        end else begin
            result[i] = old_word[i];                // kept bit
        end
    end
    return result;
endfunction

// write lands in the model at the end of the grant cycle
function automatic void model_write(
    input logic [MEM_AW-1:0] addr,
    input logic [MEM_DW-1:0] mask,
    input logic [MEM_DW-1:0] data
);
    shadow[addr] = merge_masked(shadow[addr], data, mask);
endfunction

// value a read granted now must return one cycle later
function automatic logic [MEM_DW-1:0] model_read(
    input logic [MEM_AW-1:0] addr
);
    return shadow[addr];
endfunction

// march test leaves every word at zero
function automatic void model_clear();
    for (int i = 0; i < MEM_DEPTH; i++) begin
        shadow[i] = '0;
    end
endfunction

`endif

/* tb_mem_subsys.sv */
// memory subsystem testbench with clock, reset, client stimulus, bist run, checker and watchdog
`timescale 1ns/1ps

module tb_mem_subsys;

    import mem_pkg::*;

    `include "tb_mem_model.svh"

    localparam int CLK_PERIOD  = 4;                     // ns
    localparam int DRIVE_DLY   = 1;                     // ns after rising edge
    localparam int BIST_LEN    = 6 * MEM_DEPTH + 2;     // start pulse to done pulse
    localparam int BIST_CYCLES = 6 * MEM_DEPTH + 10;
    localparam int TEST_CYCLES = 380;                   // client traffic, all tests
    localparam int WATCHDOG_NS = (TEST_CYCLES + BIST_CYCLES) * CLK_PERIOD * 2;

    logic              rd_clk;
    logic              reset;
    logic              bist_start;
    logic              req_a;
    mem_op_t           op_a;
    logic [MEM_AW-1:0] addr_a;
    logic [MEM_DW-1:0] wem_a;
    logic [MEM_DW-1:0] din_a;
    logic              req_b;
    mem_op_t           op_b;
    logic [MEM_AW-1:0] addr_b;
    logic [MEM_DW-1:0] wem_b;
    logic [MEM_DW-1:0] din_b;
    logic              gnt_a;
    logic              gnt_b;
    logic              rd_valid_a;
    logic              rd_valid_b;
    logic [MEM_DW-1:0] rd_data_a;
    logic [MEM_DW-1:0] rd_data_b;
    logic              bist_busy;
    logic              bist_done;
    logic              bist_fail;

    logic              pred_last_b;                     // checker's round-robin state
    logic [1:0]        pred_gnt;                        // {b, a}
    logic              exp_valid_a;                     // read granted last cycle
    logic              exp_valid_b;
    logic [MEM_DW-1:0] exp_q_a [$];                     // expected read data
    logic [MEM_DW-1:0] exp_q_b [$];
    int                bist_left;                       // busy cycles still to come
    logic              exp_busy;                        // predicted bist_busy
    int                data_errors;
    int                grant_errors;
    int                valid_errors;
    int                bist_errors;

    mem_subsys mem_subsys_inst (.*);

    always #(CLK_PERIOD / 2) rd_clk = ~rd_clk;

    // ##################################################################
    // reference and checker
    // ##################################################################
    // busy blocks all, lone requester wins, tie goes to the one not granted last
    function automatic logic [1:0] predict_grant(input logic ra, input logic rb,
                                                 input logic busy, input logic last_b);
        if (busy) begin
            return 2'b00;
        end
        if (ra && rb) begin
            return last_b ? 2'b01 : 2'b10;
        end
        return {rb, ra};
    endfunction

    task automatic check_return(input logic is_b, input logic valid, input logic exp_valid,
                                input logic [MEM_DW-1:0] data);
        logic [MEM_DW-1:0] expected;
        assert (valid === exp_valid) else begin
            valid_errors++;
            if (valid) begin
                $display("time %0t: unexpected read-valid pulse on client %s",
                         $time, is_b ? "b" : "a");
            end else begin
                $display("time %0t: missing read-valid pulse on client %s",
                         $time, is_b ? "b" : "a");
            end
        end
        if (exp_valid) begin
            if (is_b) begin
                expected = exp_q_b.pop_front();
            end else begin
                expected = exp_q_a.pop_front();
            end
            if (valid) begin
                assert (data === expected) else begin
                    data_errors++;
                    $display("[ERROR] %0t %s expected %h got %h", $time,
                             is_b ? "rd_data_b" : "rd_data_a", expected, data);
                end
            end
        end
    endtask

    // sampled mid-cycle, inputs and outputs settled
    always @(negedge rd_clk) begin
        if (reset) begin
            pred_last_b = 1'b1;                         // a preferred first
            exp_valid_a = 1'b0;
            exp_valid_b = 1'b0;
            bist_left   = 0;
            exp_q_a.delete();
            exp_q_b.delete();
        end else begin
            check_return(1'b0, rd_valid_a, exp_valid_a, rd_data_a);
            check_return(1'b1, rd_valid_b, exp_valid_b, rd_data_b);
            exp_busy = (bist_left != 0);
            assert (bist_busy === exp_busy) else begin
                bist_errors++;
                $display("[ERROR] %0t bist_busy expected %b got %b",
                         $time, exp_busy, bist_busy);
            end
            pred_gnt = predict_grant(req_a, req_b, exp_busy, pred_last_b);
            assert (!(gnt_a && gnt_b)) else begin
                grant_errors++;
                $display("time %0t: gnt_a and gnt_b high together", $time);
            end
            assert ({gnt_b, gnt_a} === pred_gnt) else begin
                grant_errors++;
                $display("[ERROR] %0t {gnt_b,gnt_a} expected %b got %b",
                         $time, pred_gnt, {gnt_b, gnt_a});
            end
            exp_valid_a = gnt_a && (op_a == MEM_READ);
            exp_valid_b = gnt_b && (op_b == MEM_READ);
            if (exp_valid_a) begin
                exp_q_a.push_back(model_read(addr_a));
            end
            if (exp_valid_b) begin
                exp_q_b.push_back(model_read(addr_b));
            end
            if (gnt_a && op_a == MEM_WRITE) begin
                model_write(addr_a, wem_a, din_a);
            end
            if (gnt_b && op_b == MEM_WRITE) begin
                model_write(addr_b, wem_b, din_b);
            end
            if (gnt_a || gnt_b) begin
                pred_last_b = gnt_b;
            end
            if (bist_left != 0) begin
                bist_left--;
            end else if (bist_start) begin
                bist_left = BIST_LEN - 1;               // busy from the next cycle on
                model_clear();                          // no client write until done
            end
        end
    end

    // ##################################################################
    // stimulus
    // ##################################################################
    // called at edge plus drive delay, returns the same way after the grant
    task automatic request(input logic is_b, input mem_op_t op, input logic [MEM_AW-1:0] addr,
                           input logic [MEM_DW-1:0] wem, input logic [MEM_DW-1:0] din);
        logic granted;
        if (is_b) begin
            req_b  = 1'b1;
            op_b   = op;
            addr_b = addr;
            wem_b  = wem;
            din_b  = din;
        end else begin
            req_a  = 1'b1;
            op_a   = op;
            addr_a = addr;
            wem_a  = wem;
            din_a  = din;
        end
        granted = 1'b0;
        while (!granted) begin
            @(negedge rd_clk);
            granted = is_b ? gnt_b : gnt_a;             // held until granted
        end
        @(posedge rd_clk);
        #DRIVE_DLY;
        if (is_b) begin
            req_b = 1'b0;
        end else begin
            req_a = 1'b0;
        end
    endtask

    // a takes even words, b odd, contention makes them alternate
    task automatic read_all_alternating();
        fork
            for (int i = 0; i < MEM_DEPTH; i += 2) begin
                request(1'b0, MEM_READ, MEM_AW'(i), '0, '0);
            end
            for (int i = 1; i < MEM_DEPTH; i += 2) begin
                request(1'b1, MEM_READ, MEM_AW'(i), '0, '0);
            end
        join
    endtask

    task automatic run_bist();
        int   cycles;
        logic seen_done;
        bist_start = 1'b1;                              // cycle 0
        @(negedge rd_clk);
        assert (bist_busy === 1'b0) else begin
            bist_errors++;
            $display("time %0t: bist_busy high in the start cycle", $time);
        end
        @(posedge rd_clk);
        #DRIVE_DLY;
        bist_start = 1'b0;
        cycles     = 0;
        seen_done  = 1'b0;
        while (!seen_done && cycles < BIST_CYCLES) begin
            @(negedge rd_clk);
            cycles++;
            if (bist_done) begin
                seen_done = 1'b1;
            end else begin
                assert (bist_busy === 1'b1 && !gnt_a && !gnt_b) else begin
                    bist_errors++;
                    $display("time %0t: bist not busy or client granted during test", $time);
                end
            end
        end
        assert (seen_done) else begin
            bist_errors++;
            $display("time %0t: bist_done never pulsed", $time);
        end
        if (seen_done) begin
            assert (cycles == BIST_LEN) else begin
                bist_errors++;
                $display("[ERROR] %0t bist_done cycle expected %0d got %0d",
                         $time, BIST_LEN, cycles);
            end
            assert (bist_busy === 1'b0 && bist_fail === 1'b0) else begin
                bist_errors++;
                $display("[ERROR] %0t {bist_busy,bist_fail} expected 00 got %b%b",
                         $time, bist_busy, bist_fail);
            end
            @(negedge rd_clk);
            assert (bist_done === 1'b0) else begin
                bist_errors++;
                $display("time %0t: bist_done pulse longer than one cycle", $time);
            end
        end
    endtask

    // ##################################################################
    // main sequence
    // ##################################################################
    initial begin
        void'($urandom(32'h45659352));                  // seeded once
        rd_clk     = 1'b0;
        reset      = 1'b1;
        bist_start = 1'b0;
        req_a      = 1'b0;
        op_a       = MEM_READ;
        addr_a     = '0;
        wem_a      = '0;
        din_a      = '0;
        req_b      = 1'b0;
        op_b       = MEM_READ;
        addr_b     = '0;
        wem_b      = '0;
        din_b      = '0;
        data_errors  = 0;
        grant_errors = 0;
        valid_errors = 0;
        bist_errors  = 0;
        repeat (3) @(posedge rd_clk);
        #DRIVE_DLY;
        reset = 1'b0;

        // reset state
        @(negedge rd_clk);
        assert ({gnt_a, gnt_b, rd_valid_a, rd_valid_b, bist_busy, bist_done, bist_fail}
                === 7'b0) else begin
            grant_errors++;
            $display("time %0t: outputs not all low in the cycle after reset", $time);
        end
        @(posedge rd_clk);
        #DRIVE_DLY;

        // fairness, both write full words, a first
        fork
            for (int i = 0; i < MEM_DEPTH / 2; i++) begin
                request(1'b0, MEM_WRITE, MEM_AW'(i), '1, $urandom);
            end
            for (int i = MEM_DEPTH / 2; i < MEM_DEPTH; i++) begin
                request(1'b1, MEM_WRITE, MEM_AW'(i), '1, $urandom);
            end
        join

        // basic write from a, read-back from b
        for (int i = 0; i < 16; i++) begin
            request(1'b0, MEM_WRITE, MEM_AW'($urandom_range(MEM_DEPTH - 1, 0)), '1, $urandom);
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            request(1'b1, MEM_READ, MEM_AW'(i), '0, '0);
        end

        // masked write, read by the other client in the next cycle
        for (int i = 0; i < 32; i++) begin
            addr_a = MEM_AW'($urandom_range(MEM_DEPTH - 1, 0));
            request(i[0], MEM_WRITE, addr_a, $urandom, $urandom);
            request(~i[0], MEM_READ, i[0] ? addr_b : addr_a, '0, '0);
        end

        // pipelined reads, then write and read of one word back to back
        read_all_alternating();
        for (int i = 0; i < 8; i++) begin
            request(1'b0, MEM_WRITE, MEM_AW'(i * 7), '1, $urandom);
            request(1'b0, MEM_READ, MEM_AW'(i * 7), '0, '0);
        end

        // bist with both clients held off, then all words read as zero
        fork
            run_bist();
            begin
                @(posedge rd_clk);
                #DRIVE_DLY;
                request(1'b0, MEM_READ, MEM_AW'(3), '0, '0);
            end
            begin
                @(posedge rd_clk);
                #DRIVE_DLY;
                request(1'b1, MEM_READ, MEM_AW'(9), '0, '0);
            end
        join
        @(posedge rd_clk);
        #DRIVE_DLY;
        read_all_alternating();

        repeat (2) @(negedge rd_clk);
        assert (exp_q_a.size() == 0 && exp_q_b.size() == 0) else begin
            valid_errors++;
            $display("time %0t: read data still outstanding at end of run", $time);
        end
        $display("error counts: data %0d, grant %0d, valid %0d, bist %0d",
                 data_errors, grant_errors, valid_errors, bist_errors);
        if (data_errors + grant_errors + valid_errors + bist_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // ##################################################################
    // watchdog
    // ##################################################################
    initial begin
        #(WATCHDOG_NS);
        $display("time %0t: watchdog expired, run did not finish", $time);
        $display("error counts: data %0d, grant %0d, valid %0d, bist %0d",
                 data_errors, grant_errors, valid_errors, bist_errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* project.f */
+incdir+.
mem_pkg.sv
mem_dp.sv
mem_arbiter.sv
mem_bist.sv
mem_subsys.sv
tb_mem_subsys.sv
